/* csr_addr_pkg.sv */
package csr_addr_pkg;

    localparam int CSR_NUM_W  = 14;
    localparam int CSR_DATA_W = 32;

    // Pending bits that can raise an interrupt request
    localparam int INT_W = 12;

    typedef logic [CSR_DATA_W-1:0] csr_data_t;

    typedef enum logic [CSR_NUM_W-1:0] {
        CSR_CRMD   = 14'h00,
        CSR_PRMD   = 14'h01,
        CSR_ECFG   = 14'h04,
        CSR_ESTAT  = 14'h05,
        CSR_ERA    = 14'h06,
        CSR_BADV   = 14'h07,
        CSR_EENTRY = 14'h0c,
        CSR_SAVE0  = 14'h30,
        CSR_SAVE1  = 14'h31,
        CSR_SAVE2  = 14'h32,
        CSR_SAVE3  = 14'h33,
        CSR_TCFG   = 14'h41,
        CSR_TVAL   = 14'h42,
        CSR_TICLR  = 14'h44
    } csr_num_e;

    localparam int PLV_W              = 2;
    localparam int CRMD_IE_BIT        = 2;
    localparam int LIE_W              = 13;
    // LIE bit 10 has no source and stays zero
    localparam logic [LIE_W-1:0] LIE_RW_MASK = 13'h1bff;
    localparam int EENTRY_VA_LSB      = 6;
    localparam int SW_IS_W            = 2;
    localparam int ESTAT_TI_BIT       = 11;
    localparam int ESTAT_ECODE_LSB    = 16;
    localparam int ESTAT_ESUBCODE_LSB = 22;
    localparam int TCFG_EN_BIT        = 0;
    localparam int TCFG_PERIODIC_BIT  = 1;
    localparam int TICLR_CLR_BIT      = 0;

    // Bits set in the mask come from the new value
    function automatic csr_data_t mask_merge(csr_data_t old_value, csr_data_t wmask,
                                             csr_data_t wvalue);
        return (wmask & wvalue) | (~wmask & old_value);
    endfunction

endpackage

/* exc_code_pkg.sv */
package exc_code_pkg;

    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;

    typedef enum logic [ECODE_W-1:0] {
        ECODE_INT = 6'h00,
        ECODE_ADE = 6'h08,
        ECODE_ALE = 6'h09,
        ECODE_SYS = 6'h0b,
        ECODE_BRK = 6'h0c,
        ECODE_INE = 6'h0d
    } ecode_e;

    // ADE with this subcode is a fetch error
    localparam logic [ESUBCODE_W-1:0] ESUBCODE_ADEF = 9'd0;

    // Exceptions that record a bad address
    function automatic logic is_addr_err(ecode_e code);
        return (code == ECODE_ADE) || (code == ECODE_ALE);
    endfunction

endpackage

/* csr_write_if.sv */
interface csr_write_if
    import csr_addr_pkg::*;
();

    logic      we;
    csr_num_e  num;
    csr_data_t wmask;
    csr_data_t wvalue;

    modport source (
        output we,
        output num,
        output wmask,
        output wvalue
    );

    modport sink (
        input we,
        input num,
        input wmask,
        input wvalue
    );

endinterface

/* exc_mode_regs.sv */
module exc_mode_regs
    import csr_addr_pkg::*;
    import exc_code_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    csr_write_if.sink             wr,
    input  csr_num_e              rd_num,
    input  logic                  wb_ex,
    input  ecode_e                wb_ecode,
    input  logic [ESUBCODE_W-1:0] wb_esubcode,
    input  csr_data_t             wb_pc,
    input  csr_data_t             wb_vaddr,
    input  logic                  ertn_flush,
    output csr_data_t             mode_rvalue,
    output csr_data_t             ex_entry,
    output csr_data_t             ertn_entry,
    output logic [SW_IS_W-1:0]    sw_is,
    output logic [LIE_W-1:0]      lie,
    output logic                  crmd_ie,
    output ecode_e                ecode,
    output logic [ESUBCODE_W-1:0] esubcode
);

    logic [PLV_W-1:0]                 crmd_plv;
    logic [PLV_W-1:0]                 prmd_pplv;
    logic                             prmd_pie;
    csr_data_t                        era;
    logic [CSR_DATA_W-1:EENTRY_VA_LSB] eentry_va;
    csr_data_t                        save [4];
    csr_data_t                        badv;
    csr_data_t                        wr_next;

    // Word value of one of the registers held here
    function automatic csr_data_t own_value(csr_num_e n);
        csr_data_t v;
        v = '0;
        case (n)
            CSR_CRMD: begin
                v[PLV_W-1:0]  = crmd_plv;
                v[CRMD_IE_BIT] = crmd_ie;
            end
            CSR_PRMD: begin
                v[PLV_W-1:0]  = prmd_pplv;
                v[CRMD_IE_BIT] = prmd_pie;
            end
            CSR_ECFG:   v[LIE_W-1:0] = lie;
            CSR_ERA:    v = era;
            CSR_BADV:   v = badv;
            CSR_EENTRY: v[CSR_DATA_W-1:EENTRY_VA_LSB] = eentry_va;
            CSR_SAVE0:  v = save[0];
            CSR_SAVE1:  v = save[1];
            CSR_SAVE2:  v = save[2];
            CSR_SAVE3:  v = save[3];
            default:    v = '0;
        endcase
        return v;
    endfunction

    always_comb begin
        mode_rvalue = own_value(rd_num);
        wr_next     = mask_merge(own_value(wr.num), wr.wmask, wr.wvalue);
    end

    // CRMD, exception entry wins over return and writes
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr.we && wr.num == CSR_CRMD) begin
            crmd_plv <= wr_next[PLV_W-1:0];
            crmd_ie  <= wr_next[CRMD_IE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (wr.we && wr.num == CSR_PRMD) begin
            prmd_pplv <= wr_next[PLV_W-1:0];
            prmd_pie  <= wr_next[CRMD_IE_BIT];
        end
    end

    // Software interrupt bits live in ESTAT
    always_ff @(posedge clk) begin
        if (reset) begin
            sw_is <= '0;
        end else if (wr.we && wr.num == CSR_ESTAT) begin
            sw_is <= (wr.wmask[SW_IS_W-1:0] & wr.wvalue[SW_IS_W-1:0])
                   | (~wr.wmask[SW_IS_W-1:0] & sw_is);
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ex) begin
            ecode    <= wb_ecode;
            esubcode <= wb_esubcode;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ex) begin
            era <= wb_pc;
        end else if (wr.we && wr.num == CSR_ERA) begin
            era <= wr_next;
        end
    end

    // Fetch errors report the PC itself
    always_ff @(posedge clk) begin
        if (wb_ex) begin
            if (is_addr_err(wb_ecode)) begin
                badv <= (wb_ecode == ECODE_ADE && wb_esubcode == ESUBCODE_ADEF) ?
                        wb_pc : wb_vaddr;
            end
        end else if (wr.we && wr.num == CSR_BADV) begin
            badv <= wr_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lie <= '0;
        end else if (wr.we && wr.num == CSR_ECFG) begin
            lie <= wr_next[LIE_W-1:0] & LIE_RW_MASK;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.we && wr.num == CSR_EENTRY) begin
            eentry_va <= wr_next[CSR_DATA_W-1:EENTRY_VA_LSB];
        end
        for (int i = 0; i < 4; i++) begin
            if (wr.we && wr.num == csr_num_e'(CSR_SAVE0 + i)) begin
                save[i] <= wr_next;
            end
        end
    end

    assign ex_entry   = {eentry_va, {EENTRY_VA_LSB{1'b0}}};
    assign ertn_entry = era;

endmodule

/* stable_timer.sv */
module stable_timer
    import csr_addr_pkg::*;
#(
    parameter int TIMER_W = 32
) (
    input  logic      clk,
    input  logic      reset,
    csr_write_if.sink wr,
    input  csr_num_e  rd_num,
    output csr_data_t timer_rvalue,
    output logic      timer_int
);

    logic               tcfg_en;
    logic               tcfg_periodic;
    logic [TIMER_W-3:0] tcfg_initval;
    logic [TIMER_W-1:0] timer_cnt;
    csr_data_t          tcfg_rvalue;
    csr_data_t          tcfg_next;
    logic               tcfg_wr;
    logic               ticlr_wr;

    assign tcfg_rvalue = csr_data_t'({tcfg_initval, tcfg_periodic, tcfg_en});
    assign tcfg_next   = mask_merge(tcfg_rvalue, wr.wmask, wr.wvalue);
    assign tcfg_wr     = wr.we && wr.num == CSR_TCFG;
    assign ticlr_wr    = wr.we && wr.num == CSR_TICLR
                      && wr.wmask[TICLR_CLR_BIT] && wr.wvalue[TICLR_CLR_BIT];

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en <= 1'b0;
        end else if (tcfg_wr) begin
            tcfg_en <= tcfg_next[TCFG_EN_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (tcfg_wr) begin
            tcfg_periodic <= tcfg_next[TCFG_PERIODIC_BIT];
            tcfg_initval  <= tcfg_next[TIMER_W-1:2];
        end
    end

    // Count of all ones means a one-shot run has finished
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= '1;
        end else if (tcfg_wr && tcfg_next[TCFG_EN_BIT]) begin
            timer_cnt <= {tcfg_next[TIMER_W-1:2], 2'b00};
        end else if (tcfg_en && timer_cnt != '1) begin
            if (timer_cnt == '0 && tcfg_periodic) begin
                timer_cnt <= {tcfg_initval, 2'b00};
            end else begin
                timer_cnt <= timer_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (tcfg_en && timer_cnt == '0) begin
            timer_int <= 1'b1;
        end else if (ticlr_wr) begin
            timer_int <= 1'b0;
        end
    end

    always_comb begin
        case (rd_num)
            CSR_TCFG:  timer_rvalue = tcfg_rvalue;
            CSR_TVAL:  timer_rvalue = csr_data_t'(timer_cnt);
            // Clear bit is write-only
            CSR_TICLR: timer_rvalue = '0;
            default:   timer_rvalue = '0;
        endcase
    end

endmodule

/* csr_read_irq.sv */
module csr_read_irq
    import csr_addr_pkg::*;
    import exc_code_pkg::*;
(
    input  csr_num_e              rd_num,
    input  csr_data_t             mode_rvalue,
    input  csr_data_t             timer_rvalue,
    input  logic [SW_IS_W-1:0]    sw_is,
    input  logic                  timer_int,
    input  logic [LIE_W-1:0]      lie,
    input  logic                  crmd_ie,
    input  ecode_e                ecode,
    input  logic [ESUBCODE_W-1:0] esubcode,
    output csr_data_t             rvalue,
    output logic                  has_int
);

    csr_data_t estat;
    csr_data_t estat_rvalue;

    // Hardware and inter-core bits stay zero
    always_comb begin
        estat                                     = '0;
        estat[SW_IS_W-1:0]                        = sw_is;
        estat[ESTAT_TI_BIT]                       = timer_int;
        estat[ESTAT_ECODE_LSB +: ECODE_W]         = ecode;
        estat[ESTAT_ESUBCODE_LSB +: ESUBCODE_W]   = esubcode;
    end

    assign estat_rvalue = (rd_num == CSR_ESTAT) ? estat : '0;

    // Sources return zero for numbers they do not own
    assign rvalue = mode_rvalue | timer_rvalue | estat_rvalue;

    assign has_int = (|(estat[INT_W-1:0] & lie[INT_W-1:0])) && crmd_ie;

endmodule

/* csr_file.sv */
module csr_file
    import csr_addr_pkg::*;
    import exc_code_pkg::*;
#(
    parameter int TIMER_W = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  csr_we,
    input  csr_num_e              csr_num,
    input  csr_data_t             csr_wmask,
    input  csr_data_t             csr_wvalue,
    input  csr_data_t             wb_pc,
    input  csr_data_t             wb_vaddr,
    input  logic                  wb_ex,
    input  logic                  ertn_flush,
    input  ecode_e                wb_ecode,
    input  logic [ESUBCODE_W-1:0] wb_esubcode,
    output csr_data_t             csr_rvalue,
    output csr_data_t             ex_entry,
    output csr_data_t             ertn_entry,
    output logic                  has_int
);

    csr_data_t             mode_rvalue;
    csr_data_t             timer_rvalue;
    logic [SW_IS_W-1:0]    sw_is;
    logic [LIE_W-1:0]      lie;
    logic                  crmd_ie;
    ecode_e                ecode;
    logic [ESUBCODE_W-1:0] esubcode;
    logic                  timer_int;

    csr_write_if wr ();

    assign wr.we     = csr_we;
    assign wr.num    = csr_num;
    assign wr.wmask  = csr_wmask;
    assign wr.wvalue = csr_wvalue;

    exc_mode_regs u_exc_mode_regs (
        .clk         (clk),
        .reset       (reset),
        .wr          (wr.sink),
        .rd_num      (csr_num),
        .wb_ex       (wb_ex),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .wb_vaddr    (wb_vaddr),
        .ertn_flush  (ertn_flush),
        .mode_rvalue (mode_rvalue),
        .ex_entry    (ex_entry),
        .ertn_entry  (ertn_entry),
        .sw_is       (sw_is),
        .lie         (lie),
        .crmd_ie     (crmd_ie),
        .ecode       (ecode),
        .esubcode    (esubcode)
    );

    stable_timer #(
        .TIMER_W (TIMER_W)
    ) u_stable_timer (
        .clk          (clk),
        .reset        (reset),
        .wr           (wr.sink),
        .rd_num       (csr_num),
        .timer_rvalue (timer_rvalue),
        .timer_int    (timer_int)
    );

    csr_read_irq u_csr_read_irq (
        .rd_num       (csr_num),
        .mode_rvalue  (mode_rvalue),
        .timer_rvalue (timer_rvalue),
        .sw_is        (sw_is),
        .timer_int    (timer_int),
        .lie          (lie),
        .crmd_ie      (crmd_ie),
        .ecode        (ecode),
        .esubcode     (esubcode),
        .rvalue       (csr_rvalue),
        .has_int      (has_int)
    );

endmodule

/* csr_file_assert.sv */
module csr_file_assert
    import csr_addr_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      has_int,
    input logic      wb_ex,
    input csr_num_e  csr_num,
    input csr_data_t csr_rvalue
);
    timeunit 1ns;
    timeprecision 1ps;

    assert property (@(posedge clk) reset && $past(reset) |-> !has_int)
        else $error("has_int high during reset");

    // IE as software reads it back
    assert property (@(posedge clk) disable iff (reset)
        (has_int && csr_num == CSR_CRMD) |-> csr_rvalue[CRMD_IE_BIT])
        else $error("has_int high while CRMD IE reads clear");

    // PLV is only visible when CRMD is being read
    assert property (@(posedge clk) disable iff (reset)
        wb_ex |=> (csr_num != CSR_CRMD || csr_rvalue[PLV_W-1:0] == '0))
        else $error("CRMD PLV not zero after exception entry");

endmodule

bind csr_file csr_file_assert u_csr_file_assert (
    .clk        (clk),
    .reset      (reset),
    .has_int    (has_int),
    .wb_ex      (wb_ex),
    .csr_num    (csr_num),
    .csr_rvalue (csr_rvalue)
);

/* tb_csr_file.sv */
module tb_csr_file
    import csr_addr_pkg::*;
    import exc_code_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 10;
    // Rough cycle budget of each test, in run order
    localparam int TEST_CYCLES = 250 + 40 + 30 + 80 + 220 + 120;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + 4000;
    localparam csr_data_t ONESHOT_INIT = 32'd5;
    localparam csr_data_t PERIODIC_INIT = 32'd4;

    logic                  clk;
    logic                  reset;
    logic                  csr_we;
    csr_num_e              csr_num;
    csr_data_t             csr_wmask;
    csr_data_t             csr_wvalue;
    csr_data_t             wb_pc;
    csr_data_t             wb_vaddr;
    logic                  wb_ex;
    logic                  ertn_flush;
    ecode_e                wb_ecode;
    logic [ESUBCODE_W-1:0] wb_esubcode;
    csr_data_t             csr_rvalue;
    csr_data_t             ex_entry;
    csr_data_t             ertn_entry;
    logic                  has_int;
    int                    errors;

    csr_file #(
        .TIMER_W (32)
    ) uut (
        .clk         (clk),
        .reset       (reset),
        .csr_we      (csr_we),
        .csr_num     (csr_num),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .wb_pc       (wb_pc),
        .wb_vaddr    (wb_vaddr),
        .wb_ex       (wb_ex),
        .ertn_flush  (ertn_flush),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .csr_rvalue  (csr_rvalue),
        .ex_entry    (ex_entry),
        .ertn_entry  (ertn_entry),
        .has_int     (has_int)
    );

    always #5 clk = ~clk;

    task automatic compare_word(input string test, input csr_data_t expected,
                                input csr_data_t actual);
        if (actual !== expected) begin
            $display("Error %s expected %h actual %h", test, expected, actual);
            errors++;
        end
    endtask

    task automatic write_csr(input csr_num_e num, input csr_data_t mask, input csr_data_t value);
        @(posedge clk);
        csr_we     <= 1'b1;
        csr_num    <= num;
        csr_wmask  <= mask;
        csr_wvalue <= value;
        @(posedge clk);
        csr_we <= 1'b0;
    endtask

    // Reads are combinational, so sample half a cycle later
    task automatic read_csr(input csr_num_e num, output csr_data_t value);
        @(posedge clk);
        csr_num <= num;
        @(negedge clk);
        value = csr_rvalue;
    endtask

    task automatic sample_irq(output logic value);
        @(negedge clk);
        value = has_int;
    endtask

    task automatic pulse_exception(input ecode_e code, input logic [ESUBCODE_W-1:0] subcode,
                                   input csr_data_t pc, input csr_data_t vaddr);
        @(posedge clk);
        wb_ex       <= 1'b1;
        wb_ecode    <= code;
        wb_esubcode <= subcode;
        wb_pc       <= pc;
        wb_vaddr    <= vaddr;
        @(posedge clk);
        wb_ex <= 1'b0;
    endtask

    task automatic pulse_ertn();
        @(posedge clk);
        ertn_flush <= 1'b1;
        @(posedge clk);
        ertn_flush <= 1'b0;
    endtask

    task automatic test_masked_write();
        csr_num_e  regs [6] = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_EENTRY, CSR_ERA};
        csr_data_t old_value;
        csr_data_t mask;
        csr_data_t value;
        csr_data_t expected;
        csr_data_t actual;
        foreach (regs[r]) begin
            for (int n = 0; n < 8; n++) begin
                read_csr(regs[r], old_value);
                // First pass writes every bit so the old value is known
                mask  = (n == 0) ? '1 : $urandom;
                value = $urandom;
                write_csr(regs[r], mask, value);
                expected = (old_value & ~mask) | (value & mask);
                if (regs[r] == CSR_EENTRY) begin
                    expected[5:0] = '0;
                end
                read_csr(regs[r], actual);
                compare_word("masked_write", expected, actual);
                if (regs[r] == CSR_EENTRY) begin
                    compare_word("masked_write_ex_entry", expected, ex_entry);
                end
            end
        end
    endtask

    task automatic test_exception_return();
        csr_data_t pc;
        csr_data_t actual;
        pc = $urandom & 32'hffff_fffc;
        write_csr(CSR_CRMD, 32'h7, 32'h7);
        read_csr(CSR_CRMD, actual);
        compare_word("exc_crmd_start", 32'h7, actual);
        pulse_exception(ECODE_SYS, '0, pc, '0);
        read_csr(CSR_CRMD, actual);
        compare_word("exc_crmd", 32'h0, actual);
        read_csr(CSR_PRMD, actual);
        compare_word("exc_prmd", 32'h7, actual);
        read_csr(CSR_ERA, actual);
        compare_word("exc_era", pc, actual);
        compare_word("exc_ertn_entry", pc, ertn_entry);
        read_csr(CSR_ESTAT, actual);
        compare_word("exc_ecode", 32'h0b, (actual >> 16) & 32'h3f);
        pulse_ertn();
        read_csr(CSR_CRMD, actual);
        compare_word("ertn_crmd", 32'h7, actual);
        write_csr(CSR_CRMD, 32'h7, 32'h0);
    endtask

    task automatic test_badv();
        csr_data_t pc_a;
        csr_data_t vaddr_b;
        csr_data_t actual;
        pc_a    = $urandom;
        vaddr_b = $urandom;
        pulse_exception(ECODE_ADE, ESUBCODE_ADEF, pc_a, $urandom);
        read_csr(CSR_BADV, actual);
        compare_word("badv_adef", pc_a, actual);
        pulse_exception(ECODE_ALE, 9'd0, $urandom, vaddr_b);
        read_csr(CSR_BADV, actual);
        compare_word("badv_ale", vaddr_b, actual);
        pulse_exception(ECODE_SYS, 9'd0, $urandom, $urandom);
        read_csr(CSR_BADV, actual);
        compare_word("badv_sys", vaddr_b, actual);
    endtask

    task automatic test_oneshot_timer();
        csr_data_t actual;
        csr_data_t last;
        logic      irq;
        int        polls;
        write_csr(CSR_ECFG, 32'h1fff, 32'h0);
        write_csr(CSR_CRMD, 32'h4, 32'h0);
        write_csr(CSR_TCFG, '1, (ONESHOT_INIT << 2) | 32'h1);
        last   = ONESHOT_INIT * 4 + 1;
        actual = '0;
        polls  = 0;
        while (actual != '1 && polls < 40) begin
            read_csr(CSR_TVAL, actual);
            polls++;
            if (actual != '1) begin
                if (actual >= last) begin
                    $display("Error oneshot_tval expected below %h actual %h", last, actual);
                    errors++;
                end
                last = actual;
            end
            compare_word("oneshot_irq_masked", 32'h0, has_int);
        end
        if (actual != '1) begin
            $display("One-shot timer did not wrap to all ones within %0d polls", polls);
            errors++;
        end
        read_csr(CSR_ESTAT, actual);
        compare_word("oneshot_ti", 32'h800, actual & 32'h800);
        write_csr(CSR_ECFG, 32'h800, 32'h800);
        sample_irq(irq);
        compare_word("oneshot_irq_no_ie", 32'h0, irq);
        write_csr(CSR_CRMD, 32'h4, 32'h4);
        sample_irq(irq);
        compare_word("oneshot_irq", 32'h1, irq);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        sample_irq(irq);
        compare_word("oneshot_irq_clear", 32'h0, irq);
        read_csr(CSR_TVAL, actual);
        compare_word("oneshot_tval_end", '1, actual);
    endtask

    // Polls TVAL until the timer interrupt shows up
    task automatic poll_periodic(output logic seen);
        csr_data_t actual;
        seen = 1'b0;
        for (int n = 0; n < 60 && !seen; n++) begin
            read_csr(CSR_TVAL, actual);
            if (actual > PERIODIC_INIT * 4) begin
                $display("Error periodic_tval expected at most %h actual %h",
                         PERIODIC_INIT * 4, actual);
                errors++;
            end
            seen = has_int;
        end
    endtask

    task automatic test_periodic_timer();
        csr_data_t actual;
        logic      seen;
        logic      irq;
        write_csr(CSR_TCFG, '1, (PERIODIC_INIT << 2) | 32'h3);
        poll_periodic(seen);
        if (!seen) begin
            $display("Periodic timer raised no interrupt");
            errors++;
        end
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        sample_irq(irq);
        compare_word("periodic_irq_clear", 32'h0, irq);
        poll_periodic(seen);
        if (!seen) begin
            $display("Periodic timer interrupt did not come back after the clear");
            errors++;
        end
        read_csr(CSR_ESTAT, actual);
        compare_word("periodic_ti", 32'h800, actual & 32'h800);
        write_csr(CSR_TCFG, '1, 32'h0);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
    endtask

    task automatic test_sw_interrupt();
        csr_data_t lie_value;
        logic      irq;
        logic      expected;
        for (int b = 0; b < 2; b++) begin
            // sel 0 enables nothing, 1 the matching bit, 2 the other bit
            for (int sel = 0; sel < 3; sel++) begin
                for (int ie = 0; ie < 2; ie++) begin
                    lie_value = (sel == 1) ? (32'h1 << b) :
                                (sel == 2) ? (32'h1 << (1 - b)) : 32'h0;
                    write_csr(CSR_ECFG, 32'h1fff, lie_value);
                    write_csr(CSR_CRMD, 32'h4, csr_data_t'(ie) << 2);
                    write_csr(CSR_ESTAT, 32'h3, 32'h1 << b);
                    sample_irq(irq);
                    expected = (sel == 1) && (ie == 1);
                    compare_word("sw_interrupt", expected, irq);
                    write_csr(CSR_ESTAT, 32'h3, 32'h0);
                end
            end
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h6120_adb2));
        errors      = 0;
        clk         = 1'b0;
        reset       = 1'b1;
        csr_we      = 1'b0;
        csr_num     = CSR_CRMD;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        wb_pc       = '0;
        wb_vaddr    = '0;
        wb_ex       = 1'b0;
        ertn_flush  = 1'b0;
        wb_ecode    = ECODE_INT;
        wb_esubcode = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        test_masked_write();
        test_exception_return();
        test_badv();
        test_oneshot_timer();
        test_periodic_timer();
        test_sw_interrupt();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* csr_file.f */
csr_addr_pkg.sv
exc_code_pkg.sv
csr_write_if.sv
exc_mode_regs.sv
stable_timer.sv
csr_read_irq.sv
csr_file.sv
csr_file_assert.sv
tb_csr_file.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_csr_file -f csr_file.f -o sim_csr_file

# A failed assertion stops the binary with a nonzero status
./obj_dir/sim_csr_file > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
